// ==== include/tcb_consts.svh ====
`ifndef TCB_CONSTS_SVH
`define TCB_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////////////////////////

// data width in bits
`define TCB_DAT 32
// byte lanes, one per 8 data bits
`define TCB_BYT (`TCB_DAT/8)
// byte address width
`define TCB_ADR 10
// width of the logarithmic size field
`define TCB_SIZ 2

//////////////////////////////////////////////////////////////////////
// memory and delays
//////////////////////////////////////////////////////////////////////

// number of word rows in the memory subordinate
`define TCB_MEM_DEP ((1 << `TCB_ADR) / `TCB_BYT)
// response delay of the memory subordinate
`define TCB_MEM_DLY 1
// delay seen at the top, the slice adds one register stage
`define TCB_TOP_DLY (`TCB_MEM_DLY + 1)

`endif

// ==== logic/tcb_pkg.sv ====
`include "tcb_consts.svh"

package tcb_pkg;

    //////////////////////////////////////////////////////////////////////
    // lane selection mode
    //////////////////////////////////////////////////////////////////////

    // log size: lowest 2**siz lanes, byte enable: lanes from the byt mask
    typedef enum logic {
        TCB_LOG_SIZE = 1'b0,
        TCB_BYTE_ENA = 1'b1
    } tcb_lane_mode_t;

    //////////////////////////////////////////////////////////////////////
    // bus payloads
    //////////////////////////////////////////////////////////////////////

    // request, sampled on the transfer
    typedef struct packed {
        logic                wen;  // write enable
        logic [`TCB_ADR-1:0] adr;  // byte address
        logic [`TCB_SIZ-1:0] siz;  // log2 of transfer size in bytes
        logic [`TCB_BYT-1:0] byt;  // byte enable mask
        logic [`TCB_DAT-1:0] wdt;  // write data
    } tcb_req_t;

    // response, valid a fixed delay after its transfer
    typedef struct packed {
        logic [`TCB_DAT-1:0] rdt;  // read data
        logic                err;  // error flag
    } tcb_rsp_t;

    // lane mask for one request, same rule on both sides of the slice
    function automatic logic [`TCB_BYT-1:0] tcb_lane_sel(
        input tcb_lane_mode_t      mode,
        input logic [`TCB_SIZ-1:0] siz,
        input logic [`TCB_BYT-1:0] byt
    );
        logic [`TCB_BYT-1:0] sel;
        for (int i = 0; i < `TCB_BYT; i++) begin
            if (mode == TCB_LOG_SIZE) begin
                sel[i] = (i < (1 << siz));
            end else begin
                sel[i] = byt[i];
            end
        end
        return sel;
    endfunction

endpackage

// ==== logic/tcb_response_slice.sv ====
`timescale 1ns/1ps
`include "tcb_consts.svh"

module tcb_response_slice
    import tcb_pkg::*;
#(
    parameter tcb_lane_mode_t MODE = TCB_LOG_SIZE
)(
    input  logic     man,
    input  logic     reset,
    // upstream side, the manager connects here
    input  logic     up_vld,
    input  tcb_req_t up_req,
    output logic     up_rdy,
    output tcb_rsp_t up_rsp,
    // downstream side, the subordinate connects here
    output logic     dn_vld,
    output tcb_req_t dn_req,
    input  logic     dn_rdy,
    input  tcb_rsp_t dn_rsp
);

    // stages in the delay line, one per downstream response cycle
    localparam int DLY = `TCB_MEM_DLY;

    // what the capture stage needs to know about an old transfer
    typedef struct packed {
        logic                trn;
        logic                wen;
        logic [`TCB_SIZ-1:0] siz;
        logic [`TCB_BYT-1:0] byt;
    } dly_t;

    logic                trn;
    dly_t                dly_d;
    dly_t                dly_q [DLY];
    dly_t                last;
    logic [`TCB_BYT-1:0] cap_sel;

    //////////////////////////////////////////////////////////////////////
    // request path
    //////////////////////////////////////////////////////////////////////

    // request and handshake go straight through
    assign dn_vld = up_vld;
    assign dn_req = up_req;
    assign up_rdy = dn_rdy;

    // transfer happens when both sides agree
    assign trn = up_vld & up_rdy;

    //////////////////////////////////////////////////////////////////////
    // transfer delay line
    //////////////////////////////////////////////////////////////////////

    // lane controls travel with the pulse
    // so back to back transfers each see their own request
    assign dly_d.trn = trn;
    assign dly_d.wen = up_req.wen;
    assign dly_d.siz = up_req.siz;
    assign dly_d.byt = up_req.byt;

    always_ff @(posedge man) begin
        if (reset) begin
            for (int i = 0; i < DLY; i++) begin
                dly_q[i] <= '0;
            end
        end else begin
            dly_q[0] <= dly_d;
            // shift further stages, none when the delay is one
            for (int i = 1; i < DLY; i++) begin
                dly_q[i] <= dly_q[i-1];
            end
        end
    end

    // oldest stage lines up with the downstream response
    assign last = dly_q[DLY-1];

    // lanes to capture for that response
    assign cap_sel = tcb_lane_sel(MODE, last.siz, last.byt);

    //////////////////////////////////////////////////////////////////////
    // response registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge man) begin
        if (reset) begin
            up_rsp <= '0;
        end else if (last.trn) begin
            // error follows every transfer, reads and writes
            up_rsp.err <= dn_rsp.err;
            // read data only on reads, only selected lanes
            if (!last.wen) begin
                for (int i = 0; i < `TCB_BYT; i++) begin
                    if (cap_sel[i]) begin
                        up_rsp.rdt[i*8+:8] <= dn_rsp.rdt[i*8+:8];
                    end
                end
            end
        end
    end

endmodule

// ==== logic/tcb_sram_sub.sv ====
`timescale 1ns/1ps
`include "tcb_consts.svh"

module tcb_sram_sub
    import tcb_pkg::*;
#(
    parameter tcb_lane_mode_t MODE = TCB_LOG_SIZE
)(
    input  logic     man,
    input  logic     reset,
    input  logic     vld,
    input  tcb_req_t req,
    output logic     rdy,
    output tcb_rsp_t rsp
);

    // address bits inside one word
    localparam int OFF = $clog2(`TCB_BYT);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // one row per word, lanes addressable as bytes
    logic [`TCB_BYT-1:0][7:0] mem [`TCB_MEM_DEP];

    logic                    trn;
    logic [`TCB_ADR-OFF-1:0] widx;
    logic [`TCB_BYT-1:0]     wsel;
    logic                    mis_align;
    logic                    over_size;
    logic                    err;

    //////////////////////////////////////////////////////////////////////
    // handshake
    //////////////////////////////////////////////////////////////////////

    // never stalls once out of reset
    always_ff @(posedge man) begin
        if (reset) begin
            rdy <= 1'b0;
        end else begin
            rdy <= 1'b1;
        end
    end

    assign trn = vld & rdy;

    //////////////////////////////////////////////////////////////////////
    // request decode
    //////////////////////////////////////////////////////////////////////

    // word row from the upper address bits
    assign widx = req.adr[`TCB_ADR-1:OFF];

    // lanes counted from lane zero of the addressed word
    assign wsel = tcb_lane_sel(MODE, req.siz, req.byt);

    // any offset inside the word is misaligned
    assign mis_align = (req.adr[OFF-1:0] != '0);

    // size mode only, more bytes than the bus carries
    assign over_size = (MODE == TCB_LOG_SIZE) && (int'(req.siz) > OFF);

    assign err = mis_align | over_size;

    //////////////////////////////////////////////////////////////////////
    // write port
    //////////////////////////////////////////////////////////////////////

    // an errored write is dropped
    always_ff @(posedge man) begin
        if (trn && req.wen && !err) begin
            for (int i = 0; i < `TCB_BYT; i++) begin
                if (wsel[i]) begin
                    mem[widx][i] <= req.wdt[i*8+:8];
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response
    //////////////////////////////////////////////////////////////////////

    // one cycle response
    // full word on reads, even errored ones
    // the slice picks the lanes it needs
    always_ff @(posedge man) begin
        if (reset) begin
            rsp <= '0;
        end else if (trn) begin
            rsp.err <= err;
            // read data held over writes
            if (!req.wen) begin
                rsp.rdt <= mem[widx];
            end
        end
    end

endmodule

// ==== logic/tcb_slice_top.sv ====
`timescale 1ns/1ps
`include "tcb_consts.svh"

module tcb_slice_top
    import tcb_pkg::*;
#(
    parameter tcb_lane_mode_t MODE = TCB_LOG_SIZE
)(
    input  logic     man,
    input  logic     reset,
    // upstream bus, delay is the memory delay plus one
    input  logic     vld,
    input  tcb_req_t req,
    output logic     rdy,
    output tcb_rsp_t rsp
);

    //////////////////////////////////////////////////////////////////////
    // downstream link between slice and memory
    //////////////////////////////////////////////////////////////////////

    logic     dn_vld;
    tcb_req_t dn_req;
    logic     dn_rdy;
    tcb_rsp_t dn_rsp;

    //////////////////////////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////////////////////////

    // response register slice
    tcb_response_slice #(
        .MODE (MODE)
    ) slice0 (
        .man    (man),
        .reset  (reset),
        .up_vld (vld),
        .up_req (req),
        .up_rdy (rdy),
        .up_rsp (rsp),
        .dn_vld (dn_vld),
        .dn_req (dn_req),
        .dn_rdy (dn_rdy),
        .dn_rsp (dn_rsp)
    );

    // byte lane memory, one cycle response
    tcb_sram_sub #(
        .MODE (MODE)
    ) sram0 (
        .man   (man),
        .reset (reset),
        .vld   (dn_vld),
        .req   (dn_req),
        .rdy   (dn_rdy),
        .rsp   (dn_rsp)
    );

endmodule

// ==== tb/tcb_slice_tb.sv ====
`timescale 1ns/1ps
`include "tcb_consts.svh"

module tcb_slice_tb
    import tcb_pkg::*;
#(
    // selects byte enable lanes when set
    parameter bit BYTE_MODE = 1'b0
);

    localparam tcb_lane_mode_t MODE = BYTE_MODE ? TCB_BYTE_ENA : TCB_LOG_SIZE;
    localparam string CASE_FILE = "tb/tcb_slice_cases.txt";
    localparam int MAX_CASES = 256;
    localparam int OFF = $clog2(`TCB_BYT);

    // one access as read from the cases file
    typedef struct packed {
        logic                wen;
        logic [`TCB_ADR-1:0] adr;
        logic [`TCB_SIZ-1:0] siz;
        logic [`TCB_BYT-1:0] byt;
        logic [`TCB_DAT-1:0] wdt;
        logic                wdt_rnd;   // draw write data at drive time
        logic [`TCB_DAT-1:0] rdt;
        logic                rdt_auto;  // expected read data from the byte model
        logic                err;
        logic                err_auto;  // expected error from the access rule
    } case_t;

    // response still in flight until its due cycle
    typedef struct packed {
        int                  due;
        int                  idx;
        logic [`TCB_DAT-1:0] rdt;
        logic                err;
    } expect_t;

    logic     man = 1'b0;
    logic     reset;
    logic     vld;
    tcb_req_t req;
    logic     rdy;
    tcb_rsp_t rsp;

    string               case_name [MAX_CASES];
    case_t               cases [MAX_CASES];
    int                  ncases;
    expect_t             pending [$];
    logic [7:0]          ref_mem [1 << `TCB_ADR];
    logic [`TCB_DAT-1:0] last_rdt;
    int                  cyc = 0;
    int                  cyc_limit = 0;
    int                  check_errors = 0;
    int                  tests_passed = 0;
    int                  tests_failed = 0;
    bit                  load_ok;

    //////////////////////////////////////////////////////////////////////
    // clock, cycle count, DUT
    //////////////////////////////////////////////////////////////////////

    always #5 man = ~man;

    always @(posedge man) begin
        cyc <= cyc + 1;
    end

    tcb_slice_top #(
        .MODE (MODE)
    ) dut0 (
        .man   (man),
        .reset (reset),
        .vld   (vld),
        .req   (req),
        .rdy   (rdy),
        .rsp   (rsp)
    );

    // stop a run that never drains its responses
    initial begin
        @(posedge man);
        while (cyc < cyc_limit) begin
            @(posedge man);
        end
        $display("run timed out after %0d cycles with %0d responses pending",
                 cyc, pending.size());
        $display("STATUS: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // reference rules
    //////////////////////////////////////////////////////////////////////

    // lanes a request touches counted from lane zero of the word
    function automatic logic [`TCB_BYT-1:0] lanes_of(input logic [`TCB_SIZ-1:0] siz,
                                                    input logic [`TCB_BYT-1:0] byt);
        int span;
        if (MODE == TCB_BYTE_ENA) begin
            return byt;
        end else begin
            // 2**siz ones from the bottom cut to the bus width
            span = (1 << (1 << siz)) - 1;
            return span[`TCB_BYT-1:0];
        end
    endfunction

    // misaligned address or more bytes than the bus holds in size mode
    function automatic logic access_error(input logic [`TCB_ADR-1:0] adr,
                                          input logic [`TCB_SIZ-1:0] siz);
        logic bad_size;
        bad_size = (MODE == TCB_LOG_SIZE) && ((1 << siz) > `TCB_BYT);
        return ((int'(adr) % `TCB_BYT) != 0) || bad_size;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checking and reporting
    //////////////////////////////////////////////////////////////////////

    task automatic compare_value(input string test, input string field,
                                 input logic [`TCB_DAT-1:0] expected,
                                 input logic [`TCB_DAT-1:0] actual, inout bit ok);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s expected %h actual %h",
                     test, field, expected, actual);
            check_errors++;
            ok = 1'b0;
        end
    endtask

    task automatic report_test(input string test, input bit ok);
        if (ok) begin
            tests_passed++;
            $display("test %s ok", test);
        end else begin
            tests_failed++;
            $display("test %s failed", test);
        end
    endtask

    // response cleared and bus ready once reset is released
    task automatic check_reset_state(input string test);
        bit ok;
        ok = 1'b1;
        compare_value(test, "rdt", '0, rsp.rdt, ok);
        compare_value(test, "err", '0, `TCB_DAT'(rsp.err), ok);
        compare_value(test, "rdy", `TCB_DAT'(1'b1), `TCB_DAT'(rdy), ok);
        report_test(test, ok);
    endtask

    // every response whose cycle has come
    task automatic check_due();
        expect_t e;
        bit      ok;
        while (pending.size() > 0 && pending[0].due == cyc) begin
            e = pending.pop_front();
            ok = 1'b1;
            compare_value(case_name[e.idx], "rdt", e.rdt, rsp.rdt, ok);
            compare_value(case_name[e.idx], "err", `TCB_DAT'(e.err), `TCB_DAT'(rsp.err), ok);
            report_test(case_name[e.idx], ok);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic load_cases(output bit ok);
        int          fd;
        int          got;
        string       tok;
        string       line;
        string       fld [7];
        logic [31:0] val [7];
        case_t       c;
        ok = 1'b1;
        ncases = 0;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the case file %s", CASE_FILE);
            ok = 1'b0;
        end else begin
            while (ok && $fscanf(fd, "%s", tok) == 1) begin
                if (tok.getc(0) == "#") begin
                    got = $fgets(line, fd);
                end else if (ncases == MAX_CASES) begin
                    $display("more than %0d cases in %s", MAX_CASES, CASE_FILE);
                    ok = 1'b0;
                end else begin
                    got = 0;
                    for (int i = 0; i < 7; i++) begin
                        got += $fscanf(fd, "%s", fld[i]);
                        val[i] = '0;
                        void'($sscanf(fld[i], "%h", val[i]));
                    end
                    if (got != 7) begin
                        $display("case %s has missing fields", tok);
                        ok = 1'b0;
                    end else begin
                        c = '0;
                        c.wen      = val[0][0];
                        c.adr      = val[1][`TCB_ADR-1:0];
                        c.siz      = val[2][`TCB_SIZ-1:0];
                        c.byt      = val[3][`TCB_BYT-1:0];
                        c.wdt      = val[4];
                        c.wdt_rnd  = (fld[4] == "rand");
                        c.rdt      = val[5];
                        c.rdt_auto = (fld[5] == "-");
                        c.err      = val[6][0];
                        c.err_auto = (fld[6] == "-");
                        case_name[ncases] = tok;
                        cases[ncases] = c;
                        ncases++;
                    end
                end
            end
            $fclose(fd);
            if (ok && ncases == 0) begin
                $display("the case file %s holds no cases", CASE_FILE);
                ok = 1'b0;
            end
        end
    endtask

    // put one case on the bus and queue its expected response
    task automatic drive_case(input int k);
        case_t               c;
        logic [`TCB_BYT-1:0] sel;
        logic [`TCB_ADR-1:0] base;
        logic [`TCB_DAT-1:0] wdat;
        logic [`TCB_DAT-1:0] rdt_exp;
        logic                err_rule;
        logic                err_exp;
        int                  a;
        expect_t             e;
        c = cases[k];
        wdat = c.wdt_rnd ? $urandom() : c.wdt;
        sel = lanes_of(c.siz, c.byt);
        base = {c.adr[`TCB_ADR-1:OFF], {OFF{1'b0}}};
        err_rule = access_error(c.adr, c.siz);
        // unselected lanes and writes keep the last response
        rdt_exp = last_rdt;
        for (int i = 0; i < `TCB_BYT; i++) begin
            a = int'(base) + i;
            if (sel[i] && c.wen && !err_rule) begin
                ref_mem[a] = wdat[i*8+:8];
            end else if (sel[i] && !c.wen) begin
                rdt_exp[i*8+:8] = ref_mem[a];
            end
        end
        err_exp = err_rule;
        if (!c.rdt_auto) begin
            rdt_exp = c.rdt;
        end
        if (!c.err_auto) begin
            err_exp = c.err;
        end
        last_rdt = rdt_exp;
        e.due = cyc + `TCB_TOP_DLY;
        e.idx = k;
        e.rdt = rdt_exp;
        e.err = err_exp;
        pending.push_back(e);
        req.wen = c.wen;
        req.adr = c.adr;
        req.siz = c.siz;
        req.byt = c.byt;
        req.wdt = wdat;
        vld     = 1'b1;
    endtask

    // one transfer per cycle while rdy allows and then drain
    task automatic run_cases();
        int k;
        k = 0;
        while (k < ncases || pending.size() > 0) begin
            @(negedge man);
            check_due();
            if (k < ncases && rdy) begin
                drive_case(k);
                k++;
            end else begin
                vld = 1'b0;
            end
        end
    endtask

    initial begin
        vld      = 1'b0;
        req      = '0;
        reset    = 1'b1;
        last_rdt = '0;
        void'($urandom(32'h8b7b));
        load_cases(load_ok);
        if (!load_ok) begin
            $display("no cases to run");
            $display("STATUS: FAIL");
            $finish;
        end else begin
            cyc_limit = 3 * ncases + 50;
            repeat (4) @(posedge man);
            @(negedge man);
            reset = 1'b0;
            @(negedge man);
            check_reset_state("reset_state");
            run_cases();
            // reset again while rsp still holds read data from the last case
            reset = 1'b1;
            repeat (4) @(posedge man);
            @(negedge man);
            reset = 1'b0;
            @(negedge man);
            check_reset_state("reset_after_run");
            $display("tests %0d, passed %0d, failed %0d, check errors %0d",
                     tests_passed + tests_failed, tests_passed, tests_failed, check_errors);
            if (check_errors == 0 && tests_failed == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

// ==== tb/tcb_slice_cases.txt ====
# columns: name wen adr siz byt wdt exp_rdt exp_err, numbers in hex
# wdt rand draws random data, a dash lets the testbench work the value out
# full word writes fill every word that is read later
wr_init_000 1 000 2 f 11223344 - 0
wr_init_004 1 004 2 f 55667788 - 0
wr_init_008 1 008 2 f 99aabbcc - 0
wr_init_00c 1 00c 2 f ddeeff00 - 0
wr_init_010 1 010 2 f 0badf00d - 0
wr_init_014 1 014 2 f cafef00d - 0
wr_init_018 1 018 2 f 12345678 - 0
wr_init_01c 1 01c 2 f 87654321 - 0
wr_init_020 1 020 2 f a5a5a5a5 - 0
wr_init_100 1 100 2 f rand - 0
wr_init_104 1 104 2 f rand - 0
wr_init_3fc 1 3fc 2 f fedcba98 - 0
# full word reads
rd_full_000 0 000 2 f 0 11223344 0
rd_full_004 0 004 2 f 0 55667788 0
rd_full_008 0 008 2 f 0 99aabbcc 0
rd_full_00c 0 00c 2 f 0 ddeeff00 0
rd_full_010 0 010 2 f 0 0badf00d 0
rd_full_014 0 014 2 f 0 cafef00d 0
rd_full_018 0 018 2 f 0 12345678 0
rd_full_01c 0 01c 2 f 0 87654321 0
rd_full_020 0 020 2 f 0 a5a5a5a5 0
rd_full_100 0 100 2 f 0 - 0
rd_full_104 0 104 2 f 0 - 0
rd_full_3fc 0 3fc 2 f 0 fedcba98 0
# a read right behind its write
wr_b2b_024 1 024 2 f 13579bdf - 0
rd_b2b_024 0 024 2 f 0 13579bdf 0
# partial reads keep the other lanes of the last response
rd_base_008 0 008 2 f 0 99aabbcc 0
rd_part_000 0 000 0 1 0 - 0
rd_part_004 0 004 0 4 0 - 0
rd_part_00c 0 00c 1 a 0 - 0
rd_part_010 0 010 1 5 0 - 0
rd_part_014 0 014 0 8 0 - 0
rd_part_018 0 018 1 9 0 - 0
rd_part_01c 0 01c 0 6 0 - 0
rd_part_020 0 020 1 3 0 - 0
rd_part_3fc 0 3fc 0 c 0 - 0
rd_part_100 0 100 1 e 0 - 0
rd_part_104 0 104 0 7 0 - 0
rd_none_000 0 000 0 0 0 - 0
# partial writes, a full read shows the old bytes around them
wr_part_000 1 000 0 2 aabbccdd - 0
rd_chk_000 0 000 2 f 0 - 0
wr_part_004 1 004 1 c 01020304 - 0
rd_chk_004 0 004 2 f 0 - 0
wr_part_008 1 008 0 8 f1f2f3f4 - 0
rd_chk_008 0 008 2 f 0 - 0
wr_part_00c 1 00c 1 6 c0c1c2c3 - 0
rd_chk_00c 0 00c 2 f 0 - 0
wr_part_010 1 010 0 9 rand - 0
rd_chk_010 0 010 2 f 0 - 0
wr_part_014 1 014 1 5 rand - 0
rd_chk_014 0 014 2 f 0 - 0
wr_part_018 1 018 0 0 e0e1e2e3 - 0
rd_chk_018 0 018 2 f 0 - 0
# misaligned and oversized requests
rd_mis_001 0 001 0 1 0 - 1
rd_mis_002 0 002 1 3 0 - 1
rd_mis_003 0 003 0 8 0 - 1
wr_mis_005 1 005 0 1 deadbeef - 1
rd_after_005 0 004 2 f 0 - 0
wr_mis_00a 1 00a 1 3 deadbeef - 1
wr_mis_00f 1 00f 2 f deadbeef - 1
rd_after_00a 0 008 2 f 0 - 0
rd_after_00f 0 00c 2 f 0 - 0
rd_big_000 0 000 3 f 0 - -
wr_big_01c 1 01c 3 f 5a5a5a5a - -
rd_after_01c 0 01c 2 f 0 - 0
wr_big_020 1 020 3 0 77777777 - -
rd_after_020 0 020 2 f 0 - 0
# mixed burst, one transfer in every cycle
mix_wr_200 1 200 2 f 20202020 - 0
mix_wr_204 1 204 2 f rand - 0
mix_rd_200 0 200 2 f 0 20202020 0
mix_wr_200b 1 200 0 4 abababab - 0
mix_rd_204 0 204 2 f 0 - 0
mix_rd_200b 0 200 2 f 0 - 0
mix_wr_202 1 202 2 f 11111111 - 1
mix_rd_200c 0 200 1 3 0 - 0
mix_wr_208 1 208 2 f 0f0f0f0f - 0
mix_rd_208 0 208 0 1 0 - 0
mix_rd_20b 0 20b 0 1 0 - 1
mix_rd_208b 0 208 2 f 0 0f0f0f0f 0
mix_wr_3fc 1 3fc 1 3 rand - 0
mix_rd_3fc 0 3fc 2 f 0 - 0
mix_rd_000 0 000 2 f 0 - 0

// ==== files.f ====
+incdir+include
logic/tcb_pkg.sv
logic/tcb_response_slice.sv
logic/tcb_sram_sub.sv
logic/tcb_slice_top.sv
tb/tcb_slice_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench once per lane mode with Verilator
set -e
cd "$(dirname "$0")"

for mode in 0 1; do
    obj="obj_dir_mode${mode}"
    verilator --binary --timing -f files.f --top-module tcb_slice_tb \
        -GBYTE_MODE=${mode} --Mdir "${obj}" -o tcb_slice_sim
    out=$("./${obj}/tcb_slice_sim")
    echo "${out}"
    if ! grep -q "STATUS: PASS" <<< "${out}"; then
        echo "lane mode ${mode} did not pass"
        exit 1
    fi
done

exit 0
